// ==== source/fetch_pkg.sv ====
/*
 * Shared sizes and reset address for the fetch subsystem
 * Packed structs for memory requests, responses and decode output
 */

`default_nettype none

package fetch_pkg;

  // ----------------------------
  // Sizes and addresses
  // ----------------------------

  // First fetch address after reset
  localparam logic [31:0] rst_addr = 32'h200;

  // Outstanding read limit and counter width
  localparam int max_in_flight  = 4;
  localparam int in_flight_bits = 3;

  // Instruction memory geometry, byte address bits 9:2 pick the word
  localparam int mem_words     = 256;
  localparam int mem_addr_bits = 8;

  localparam int seq_num_bits = 8;

  // ----------------------------
  // Channel payloads
  // ----------------------------

  typedef struct packed {
    logic [31:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } mem_resp_t;

  typedef struct packed {
    logic [31:0]             pc;
    logic [31:0]             inst;
    logic [seq_num_bits-1:0] seq_num;
  } fetch_out_t;

endpackage

`default_nettype wire

// ==== source/seq_num_gen.sv ====
/*
 * Squash tracking for reads in flight across a redirect
 * Gap-free sequence numbers for instructions taken by decode
 */

`default_nettype none

module seq_num_gen (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                redirect_val,
  input  logic [fetch_pkg::in_flight_bits-1:0] num_in_flight,
  input  logic                                resp_xfer,
  input  logic                                resp_val,
  input  logic                                dec_xfer,
  output logic                                resp_live,
  output logic [fetch_pkg::seq_num_bits-1:0]  seq_num
);

  // ----------------------------
  // Squash counter
  // ----------------------------

  // Responses still owed from before the last redirect
  logic [fetch_pkg::in_flight_bits-1:0] squash_cnt;
  logic [fetch_pkg::in_flight_bits-1:0] squash_load;

  // Reads left outstanding once this cycle's response is gone
  always_comb begin
    squash_load = num_in_flight - {{(fetch_pkg::in_flight_bits-1){1'b0}}, resp_xfer};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      squash_cnt <= '0;
    end else if (redirect_val) begin
      // Redirect wins over a decrement in the same cycle
      squash_cnt <= squash_load;
    end else if (resp_xfer && (squash_cnt != '0)) begin
      squash_cnt <= squash_cnt - 1'b1;
    end
  end

  // Response in the redirect cycle is stale too
  always_comb begin
    resp_live = resp_val && !redirect_val && (squash_cnt == '0);
  end

  // ----------------------------
  // Sequence numbers
  // ----------------------------

  logic [fetch_pkg::seq_num_bits-1:0] seq_cnt;

  // Only decode transfers consume a number, wraps at 256
  always_ff @(posedge clk) begin
    if (rst) begin
      seq_cnt <= '0;
    end else if (dec_xfer) begin
      seq_cnt <= seq_cnt + 1'b1;
    end
  end

  always_comb begin
    seq_num = seq_cnt;
  end

  // ----------------------------
  // Checks
  // ----------------------------

  // Every squash is backed by a read the fetch unit still counts,
  // so the counter cannot step below zero
  squash_bounded_a: assert property (
    @(posedge clk) disable iff (rst)
    squash_cnt <= num_in_flight
  );

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
/*
 * Fetch unit with in-flight read counting and next address tracking
 * Steers memory responses to decode or drops them after a redirect
 */

`default_nettype none

module fetch_unit (
  input  logic                  clk,
  input  logic                  rst,

  // Redirect pulse
  input  logic                  redirect_val,
  input  logic [31:0]           redirect_pc,

  // Memory request channel
  output logic                  req_val,
  output fetch_pkg::mem_req_t   req,
  input  logic                  req_rdy,

  // Memory response channel
  input  logic                  resp_val,
  input  fetch_pkg::mem_resp_t  resp,
  output logic                  resp_rdy,

  // Decode channel
  output logic                  dec_val,
  output fetch_pkg::fetch_out_t dec,
  input  logic                  dec_rdy
);

  logic req_xfer;
  logic resp_xfer;
  logic dec_xfer;

  always_comb begin
    req_xfer  = req_val && req_rdy;
    resp_xfer = resp_val && resp_rdy;
    dec_xfer  = dec_val && dec_rdy;
  end

  // ----------------------------
  // In-flight reads
  // ----------------------------

  logic [fetch_pkg::in_flight_bits-1:0] num_in_flight;

  always_ff @(posedge clk) begin
    if (rst) begin
      num_in_flight <= '0;
    end else if (req_xfer && !resp_xfer) begin
      num_in_flight <= num_in_flight + 1'b1;
    end else if (resp_xfer && !req_xfer) begin
      num_in_flight <= num_in_flight - 1'b1;
    end
  end

  // ----------------------------
  // Next fetch address
  // ----------------------------

  logic [31:0] curr_addr;

  // No request goes out in a redirect cycle, so the two never collide
  always_ff @(posedge clk) begin
    if (rst) begin
      curr_addr <= fetch_pkg::rst_addr;
    end else if (redirect_val) begin
      curr_addr <= redirect_pc;
    end else if (req_xfer) begin
      curr_addr <= curr_addr + 32'd4;
    end
  end

  // Issue while below the read limit and not redirecting
  always_comb begin
    req_val  = (num_in_flight < fetch_pkg::max_in_flight) && !redirect_val;
    req.addr = curr_addr;
  end

  // ----------------------------
  // Squash and numbering
  // ----------------------------

  logic                               resp_live;
  logic [fetch_pkg::seq_num_bits-1:0] seq_num;

  seq_num_gen seq_gen (
    .clk           (clk),
    .rst           (rst),
    .redirect_val  (redirect_val),
    .num_in_flight (num_in_flight),
    .resp_xfer     (resp_xfer),
    .resp_val      (resp_val),
    .dec_xfer      (dec_xfer),
    .resp_live     (resp_live),
    .seq_num       (seq_num)
  );

  // ----------------------------
  // Response steering
  // ----------------------------

  // Live responses wait on decode, dead ones drain at once
  always_comb begin
    resp_rdy    = dec_rdy || !resp_live;
    dec_val     = resp_live;
    dec.pc      = resp.addr;
    dec.inst    = resp.data;
    dec.seq_num = seq_num;
  end

  // Request side never overruns the read limit
  in_flight_bounded_a: assert property (
    @(posedge clk) disable iff (rst)
    num_in_flight <= fetch_pkg::max_in_flight
  );

endmodule

`default_nettype wire

// ==== source/inst_mem.sv ====
/*
 * Instruction memory with a word-wide load port
 * Read pipeline with request register, array read and output stage
 */

`default_nettype none

module inst_mem (
  input  logic                                clk,
  input  logic                                rst,

  // Load port, one word per cycle
  input  logic                                load_en,
  input  logic [fetch_pkg::mem_addr_bits-1:0] load_addr,
  input  logic [31:0]                         load_data,

  // Read request channel
  input  logic                                req_val,
  input  fetch_pkg::mem_req_t                 req,
  output logic                                req_rdy,

  // Read response channel
  output logic                                resp_val,
  output fetch_pkg::mem_resp_t                resp,
  input  logic                                resp_rdy
);

  // ----------------------------
  // Storage
  // ----------------------------

  logic [31:0] mem [fetch_pkg::mem_words];

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // ----------------------------
  // Pipeline registers
  // ----------------------------

  // Accepted request address
  logic        acc_val;
  logic [31:0] acc_addr;

  // Word read from the array with its address
  logic                 rd_val;
  fetch_pkg::mem_resp_t rd_q;

  // Response held for the fetch unit
  logic                 out_val;
  fetch_pkg::mem_resp_t out_q;

  // Word index, upper address bits wrap
  logic [fetch_pkg::mem_addr_bits-1:0] acc_idx;

  always_comb begin
    acc_idx = acc_addr[fetch_pkg::mem_addr_bits+1:2];
  end

  // Stage moves when the next one is empty or emptying
  logic out_adv;
  logic rd_adv;
  logic acc_adv;
  logic req_xfer;

  always_comb begin
    out_adv  = !out_val || resp_rdy;
    rd_adv   = !rd_val || out_adv;
    acc_adv  = !acc_val || rd_adv;
    // Blocked whenever the output is stuck
    req_rdy  = out_adv && acc_adv;
    req_xfer = req_val && req_rdy;
  end

  // Valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      acc_val <= 1'b0;
      rd_val  <= 1'b0;
      out_val <= 1'b0;
    end else begin
      if (acc_adv) begin
        acc_val <= req_xfer;
      end
      if (rd_adv) begin
        rd_val <= acc_val;
      end
      if (out_adv) begin
        out_val <= rd_val;
      end
    end
  end

  // Payload, loaded only alongside a valid entry
  always_ff @(posedge clk) begin
    if (req_xfer) begin
      acc_addr <= req.addr;
    end
    if (rd_adv && acc_val) begin
      rd_q.addr <= acc_addr;
      rd_q.data <= mem[acc_idx];
    end
    if (out_adv && rd_val) begin
      out_q <= rd_q;
    end
  end

  always_comb begin
    resp_val = out_val;
    resp     = out_q;
  end

  // Held response keeps its valid and payload
  resp_stable_a: assert property (
    @(posedge clk) disable iff (rst)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp))
  );

endmodule

`default_nettype wire

// ==== source/fetch_top.sv ====
/*
 * Top level of the fetch subsystem
 * Fetch unit wired to the instruction memory
 */

`default_nettype none

module fetch_top (
  input  logic                                clk,
  input  logic                                rst,

  // Memory load port
  input  logic                                load_en,
  input  logic [fetch_pkg::mem_addr_bits-1:0] load_addr,
  input  logic [31:0]                         load_data,

  // Redirect pulse
  input  logic                                redirect_val,
  input  logic [31:0]                         redirect_pc,

  // Decode channel
  output logic                                dec_val,
  output fetch_pkg::fetch_out_t               dec,
  input  logic                                dec_rdy
);

  // ----------------------------
  // Memory channels
  // ----------------------------

  logic                 req_val;
  fetch_pkg::mem_req_t  req;
  logic                 req_rdy;
  logic                 resp_val;
  fetch_pkg::mem_resp_t resp;
  logic                 resp_rdy;

  fetch_unit fetch (
    .clk          (clk),
    .rst          (rst),
    .redirect_val (redirect_val),
    .redirect_pc  (redirect_pc),
    .req_val      (req_val),
    .req          (req),
    .req_rdy      (req_rdy),
    .resp_val     (resp_val),
    .resp         (resp),
    .resp_rdy     (resp_rdy),
    .dec_val      (dec_val),
    .dec          (dec),
    .dec_rdy      (dec_rdy)
  );

  inst_mem imem (
    .clk       (clk),
    .rst       (rst),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .req_val   (req_val),
    .req       (req),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .resp      (resp),
    .resp_rdy  (resp_rdy)
  );

endmodule

`default_nettype wire

// ==== sim/fetch_tb_tasks.svh ====
/*
 * Directed tests for the fetch subsystem
 * Reset stream, decode stalls, single and back-to-back redirects
 */

`ifndef FETCH_TB_TASKS_SVH
`define FETCH_TB_TASKS_SVH

  // First 16 after reset, 3 cycle latency, one per cycle after that
  task automatic first_fetch_after_reset();
    int err_before;
    int lat;
    err_before = err_cnt;
    dec_rdy    = 1'b1;
    reset_and_load(8'h11);
    lat = 0;
    while (!dec_val && lat < 20) begin
      @(negedge clk);
      lat++;
    end
    if (!dec_val) begin
      $display("Timeout at %0t: decode valid never rose after reset", $time);
      err_cnt++;
    end else if (lat != 3) begin
      report_mismatch("cycles to first decode valid", lat, 3);
    end
    wait_transfers(16, 40);
    for (int k = 1; k < seen_cyc.size(); k++) begin
      if (seen_cyc[k] - seen_cyc[k-1] != 1) begin
        report_mismatch("transfer spacing", seen_cyc[k] - seen_cyc[k-1], 1);
      end
    end
    drain_and_check();
    finish_test(1, "first fetch after reset", err_before);
  endtask

  // Decode ready toggles at random, 60 instructions in order
  task automatic random_decode_stall();
    int          err_before;
    int          waited;
    logic [31:0] rnd;
    err_before = err_cnt;
    reset_and_load(8'h5c);
    waited = 0;
    while (seen_q.size() < 60 && waited < 600) begin
      rnd     = $urandom;
      dec_rdy = rnd[0];
      @(negedge clk);
      waited++;
    end
    dec_rdy = 1'b0;
    if (seen_q.size() < 60) begin
      $display("Timeout at %0t: random stall run gave only %0d instructions",
               $time, seen_q.size());
      err_cnt++;
    end
    drain_and_check();
    finish_test(2, "random decode stall", err_before);
  endtask

  // Long stall, then the stream resumes at the next pc
  task automatic long_decode_stall();
    int          err_before;
    logic [31:0] held_pc;
    err_before = err_cnt;
    dec_rdy    = 1'b1;
    reset_and_load(8'ha7);
    wait_transfers(8, 40);
    dec_rdy = 1'b0;
    // Ninth instruction sits at the decode port for the whole stall
    held_pc = exp_pc + 32'd32;
    for (int c = 0; c < 40; c++) begin
      @(negedge clk);
      if (!dec_val) begin
        $display("Error at %0t: decode valid dropped during the stall", $time);
        err_cnt++;
      end else if (dec.pc !== held_pc) begin
        report_mismatch("pc held during stall", dec.pc, held_pc);
      end
    end
    dec_rdy = 1'b1;
    wait_transfers(28, 60);
    // Back to one per cycle once decode is ready again
    for (int k = 9; k < seen_cyc.size(); k++) begin
      if (seen_cyc[k] - seen_cyc[k-1] != 1) begin
        report_mismatch("transfer spacing", seen_cyc[k] - seen_cyc[k-1], 1);
      end
    end
    drain_and_check();
    finish_test(3, "long decode stall", err_before);
  endtask

  // Redirect mid stream, stale reads must never reach decode
  task automatic single_redirect();
    int err_before;
    err_before = err_cnt;
    dec_rdy    = 1'b1;
    drain_and_check();
    wait_transfers(5, 20);
    drain_and_check();
    redirect_val = 1'b1;
    redirect_pc  = 32'h040;
    exp_pc       = 32'h040;
    @(negedge clk);
    redirect_val = 1'b0;
    wait_transfers(20, 60);
    drain_and_check();
    finish_test(4, "single redirect", err_before);
  endtask

  // Second redirect two cycles later wins, index wraps past 255
  task automatic back_to_back_redirects();
    int err_before;
    err_before = err_cnt;
    dec_rdy    = 1'b1;
    drain_and_check();
    wait_transfers(3, 20);
    drain_and_check();
    redirect_val = 1'b1;
    redirect_pc  = 32'h100;
    exp_pc       = 32'h3f8;
    @(negedge clk);
    redirect_val = 1'b0;
    @(negedge clk);
    redirect_val = 1'b1;
    redirect_pc  = 32'h3f8;
    @(negedge clk);
    redirect_val = 1'b0;
    wait_transfers(20, 60);
    drain_and_check();
    finish_test(5, "back to back redirects", err_before);
  endtask

`endif

// ==== sim/fetch_tb.sv ====
/*
 * Testbench for the fetch subsystem
 * Clock, reset and load, DUT, decode monitor and check helpers
 */

`default_nettype none

module fetch_tb;

  timeunit 1ns;
  timeprecision 1ps;

  logic                                clk;
  logic                                rst;
  logic                                load_en;
  logic [fetch_pkg::mem_addr_bits-1:0] load_addr;
  logic [31:0]                         load_data;
  logic                                redirect_val;
  logic [31:0]                         redirect_pc;
  logic                                dec_val;
  fetch_pkg::fetch_out_t               dec;
  logic                                dec_rdy;

  // Words as loaded, by word index
  logic [31:0] mem_img [fetch_pkg::mem_words];

  // Decode transfers and the cycle of each
  fetch_pkg::fetch_out_t seen_q[$];
  int                    seen_cyc[$];
  int                    cycle_cnt;

  // Next instruction decode should see
  logic [31:0]                        exp_pc;
  logic [fetch_pkg::seq_num_bits-1:0] exp_seq;

  int err_cnt;
  int test_cnt;
  int fail_cnt;

  fetch_top uut (
    .clk          (clk),
    .rst          (rst),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .redirect_val (redirect_val),
    .redirect_pc  (redirect_pc),
    .dec_val      (dec_val),
    .dec          (dec),
    .dec_rdy      (dec_rdy)
  );

  always #10 clk = ~clk;

  // ------------------------------
  // Decode monitor
  // ------------------------------

  // Values read here are from before this edge's register updates
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (!rst && dec_val && dec_rdy) begin
      seen_q.push_back(dec);
      seen_cyc.push_back(cycle_cnt);
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  // Every byte of the word depends on the index
  function automatic logic [31:0] fill_word(input logic [7:0] idx, input logic [7:0] salt);
    return {idx ^ salt, ~idx, idx + salt, idx};
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
    err_cnt++;
  endtask

  // Pc steps by 4, data from the loaded image, seq_num without gaps
  task automatic check_entry(input fetch_pkg::fetch_out_t got);
    logic [31:0] exp_inst;
    exp_inst = mem_img[exp_pc[9:2]];
    if (got.pc !== exp_pc) report_mismatch("pc", got.pc, exp_pc);
    if (got.inst !== exp_inst) report_mismatch("inst", got.inst, exp_inst);
    if (got.seq_num !== exp_seq) report_mismatch("seq_num", got.seq_num, exp_seq);
    exp_pc  = exp_pc + 32'd4;
    exp_seq = exp_seq + 1'b1;
  endtask

  task automatic drain_and_check();
    fetch_pkg::fetch_out_t got;
    while (seen_q.size() > 0) begin
      got = seen_q.pop_front();
      check_entry(got);
    end
    // Stamps are pushed in step with the entries
    seen_cyc.delete();
  endtask

  task automatic wait_transfers(input int n, input int limit);
    int waited;
    waited = 0;
    while (seen_q.size() < n && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (seen_q.size() < n) begin
      $display("Timeout at %0t: only %0d of %0d decode transfers arrived",
               $time, seen_q.size(), n);
      err_cnt++;
    end
  endtask

  // Load the whole memory under reset, then 4 more reset cycles
  task automatic reset_and_load(input logic [7:0] salt);
    @(negedge clk);
    rst          = 1'b1;
    redirect_val = 1'b0;
    for (int i = 0; i < fetch_pkg::mem_words; i++) begin
      load_en    = 1'b1;
      load_addr  = i[7:0];
      load_data  = fill_word(i[7:0], salt);
      mem_img[i] = load_data;
      @(negedge clk);
    end
    load_en = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    seen_q.delete();
    seen_cyc.delete();
    exp_pc  = 32'h200;
    exp_seq = '0;
  endtask

  task automatic finish_test(input int num, input string name, input int err_before);
    test_cnt++;
    if (err_cnt != err_before) begin
      fail_cnt++;
      $display("test %0d %s: failed with %0d errors", num, name, err_cnt - err_before);
    end else begin
      $display("test %0d %s: ok", num, name);
    end
  endtask

  `include "fetch_tb_tasks.svh"

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    void'($urandom(32'hfe09));
    clk          = 1'b0;
    rst          = 1'b1;
    load_en      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    redirect_val = 1'b0;
    redirect_pc  = '0;
    dec_rdy      = 1'b0;
    cycle_cnt    = 0;
    err_cnt      = 0;
    test_cnt     = 0;
    fail_cnt     = 0;
    exp_pc       = 32'h200;
    exp_seq      = '0;

    first_fetch_after_reset();
    random_decode_stall();
    long_decode_stall();
    single_redirect();
    back_to_back_redirects();

    $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+sim
source/fetch_pkg.sv
source/seq_num_gen.sv
source/fetch_unit.sv
source/inst_mem.sv
source/fetch_top.sv
sim/fetch_tb.sv
